// ==== design/cpuPkg.sv ====
package cpuPkg;

    // Basic widths
    typedef logic [15:0] word_t;
    typedef logic [3:0]  regIdx_t;

    // Flag bits, in the order Z, V, N
    typedef logic [2:0] flags_t;

    localparam int FLAG_Z = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_N = 0;

    // Default memory sizes, in words
    localparam int IMEM_AW = 8;
    localparam int DMEM_AW = 8;

    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_XOR = 4'h2,
        OP_SLL = 4'h3,
        OP_LW  = 4'h8,
        OP_SW  = 4'h9,
        OP_LLB = 4'hA,
        OP_B   = 4'hC,
        OP_HLT = 4'hF
    } opcode_t;

    // Branch condition field, instr[11:9]
    typedef enum logic [2:0] {
        COND_NE,
        COND_EQ,
        COND_GT,
        COND_LT,
        COND_GE,
        COND_LE,
        COND_OV,
        COND_ALWAYS
    } cond_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL} aluOp_t;
    typedef enum logic [1:0] {SRC_REG, SRC_SHAMT, SRC_OFFSET, SRC_BYTE} srcSel_t;
    typedef enum logic {WB_ALU, WB_MEM} wbSel_t;
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdSel_t;

    // LLB r0, 0 has no visible effect, used for flushes and reset
    localparam word_t NOP_INSTR = 16'hA000;

endpackage

// ==== design/pipeIf.sv ====
`timescale 1ns/10ps

// Contents of the decode/execute register
interface decodeExIf;
    import cpuPkg::*;

    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    halt;
    logic    zEn;
    logic    vEn;
    logic    nEn;
    aluOp_t  aluOp;
    srcSel_t srcSel;
    wbSel_t  wbSel;
    regIdx_t rs;
    regIdx_t rt;
    regIdx_t rd;
    word_t   regData1;
    word_t   regData2;
    word_t   shamt;
    word_t   offset;
    word_t   byteImm;

    modport src (
        output regWrite, memRead, memWrite, halt, zEn, vEn, nEn,
        output aluOp, srcSel, wbSel, rs, rt, rd,
        output regData1, regData2, shamt, offset, byteImm
    );

    modport dst (
        input regWrite, memRead, memWrite, halt, zEn, vEn, nEn,
        input aluOp, srcSel, wbSel, rs, rt, rd,
        input regData1, regData2, shamt, offset, byteImm
    );
endinterface

// Contents of the execute/memory register
interface exMemIf;
    import cpuPkg::*;

    logic    regWrite;
    logic    memWrite;
    logic    halt;
    wbSel_t  wbSel;
    regIdx_t rt;
    regIdx_t rd;
    word_t   aluOut;
    word_t   storeData;

    modport src (output regWrite, memWrite, halt, wbSel, rt, rd, aluOut, storeData);
    modport dst (input regWrite, memWrite, halt, wbSel, rt, rd, aluOut, storeData);
endinterface

// ==== design/fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage #(
    parameter int IMEM_AW = cpuPkg::IMEM_AW
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               loadEn,
    input  logic [IMEM_AW-1:0] loadAddr,
    input  cpuPkg::word_t      loadData,
    input  logic               stall,
    input  logic               branchTaken,
    input  cpuPkg::word_t      branchPc,
    output cpuPkg::word_t      pc,
    output cpuPkg::word_t      instr,
    output cpuPkg::word_t      incPc
);
    import cpuPkg::*;

    word_t imem [2**IMEM_AW];
    word_t fetchInstr;
    word_t nextIncPc;
    logic  fetchHlt;

    // Program load port
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    // Word addressed, pc is a byte address
    assign fetchInstr = imem[pc[IMEM_AW:1]];
    assign nextIncPc  = pc + 16'd2;
    assign fetchHlt   = opcode_t'(fetchInstr[15:12]) == OP_HLT;

    // Branch redirect wins over a HLT fetched behind it
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchPc;
        end else if (!stall && !fetchHlt) begin
            pc <= nextIncPc;
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk) begin
        if (rst || branchTaken) begin
            instr <= NOP_INSTR;
        end else if (!stall) begin
            instr <= fetchInstr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            incPc <= nextIncPc;
        end
    end

    // Instruction memory is only written while the core sits in reset
    loadOnlyInReset: assert property (@(posedge clk) loadEn |-> rst);

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::regIdx_t rs,
    input  cpuPkg::regIdx_t rt,
    output cpuPkg::word_t   data1,
    output cpuPkg::word_t   data2,
    input  logic            wbEn,
    input  cpuPkg::regIdx_t wbReg,
    input  cpuPkg::word_t   wbData
);
    import cpuPkg::*;

    word_t regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbReg != '0) begin
            regs[wbReg] <= wbData;
        end
    end

    // Same-cycle write is visible to the read, r0 is hardwired
    assign data1 = (rs == '0) ? '0 : (wbEn && wbReg == rs) ? wbData : regs[rs];
    assign data2 = (rt == '0) ? '0 : (wbEn && wbReg == rt) ? wbData : regs[rt];

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::word_t   instr,
    input  cpuPkg::word_t   incPc,
    input  cpuPkg::flags_t  flags,
    input  logic            exSetsFlags,
    input  logic            exMemRead,
    input  cpuPkg::regIdx_t exRt,
    input  cpuPkg::word_t   data1,
    input  cpuPkg::word_t   data2,
    output cpuPkg::regIdx_t rs,
    output cpuPkg::regIdx_t rt,
    output logic            stall,
    output logic            branchTaken,
    output cpuPkg::word_t   branchPc,
    decodeExIf.src          toEx
);
    import cpuPkg::*;

    opcode_t opcode;
    cond_t   cond;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    halt;
    logic    zEn;
    logic    vEn;
    logic    nEn;
    aluOp_t  aluOp;
    srcSel_t srcSel;
    wbSel_t  wbSel;
    logic    useRs;
    logic    hazRt;
    logic    isBranch;
    logic    condMet;
    logic    loadUse;
    logic    flagWait;

    assign opcode = opcode_t'(instr[15:12]);
    assign cond   = cond_t'(instr[11:9]);

    // Control decode
    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        halt     = 1'b0;
        zEn      = 1'b0;
        vEn      = 1'b0;
        nEn      = 1'b0;
        aluOp    = ALU_ADD;
        srcSel   = SRC_REG;
        wbSel    = WB_ALU;
        useRs    = 1'b0;
        hazRt    = 1'b0;
        isBranch = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB: begin
                regWrite = 1'b1;
                {zEn, vEn, nEn} = 3'b111;
                aluOp    = (opcode == OP_SUB) ? ALU_SUB : ALU_ADD;
                useRs    = 1'b1;
                hazRt    = 1'b1;
            end
            OP_XOR: begin
                regWrite = 1'b1;
                zEn      = 1'b1;
                aluOp    = ALU_XOR;
                useRs    = 1'b1;
                hazRt    = 1'b1;
            end
            OP_SLL: begin
                regWrite = 1'b1;
                zEn      = 1'b1;
                aluOp    = ALU_SLL;
                srcSel   = SRC_SHAMT;
                useRs    = 1'b1;
            end
            OP_LW: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                srcSel   = SRC_OFFSET;
                wbSel    = WB_MEM;
                useRs    = 1'b1;
            end
            // Store data needs no stall, it is caught by MEM-MEM forwarding
            OP_SW: begin
                memWrite = 1'b1;
                srcSel   = SRC_OFFSET;
                useRs    = 1'b1;
            end
            OP_LLB: begin
                regWrite = 1'b1;
                srcSel   = SRC_BYTE;
            end
            OP_B:    isBranch = 1'b1;
            OP_HLT:  halt = 1'b1;
            default: ;
        endcase
    end

    // LLB adds its byte to r0; loads and stores carry their data register in [11:8]
    assign rs = (opcode == OP_LLB) ? '0 : instr[7:4];
    assign rt = (opcode == OP_LW || opcode == OP_SW) ? instr[11:8] : instr[3:0];

    always_comb begin
        case (cond)
            COND_NE: condMet = !flags[FLAG_Z];
            COND_EQ: condMet = flags[FLAG_Z];
            COND_GT: condMet = !flags[FLAG_Z] && !flags[FLAG_N];
            COND_LT: condMet = flags[FLAG_N];
            COND_GE: condMet = flags[FLAG_Z] || !flags[FLAG_N];
            COND_LE: condMet = flags[FLAG_Z] || flags[FLAG_N];
            COND_OV: condMet = flags[FLAG_V];
            default: condMet = 1'b1;
        endcase
    end

    // Hazards
    assign loadUse  = exMemRead && ((useRs && exRt == rs) || (hazRt && exRt == rt));
    assign flagWait = isBranch && exSetsFlags;
    assign stall    = loadUse || flagWait;

    assign branchTaken = isBranch && condMet && !flagWait;
    assign branchPc    = incPc + {{6{instr[8]}}, instr[8:0], 1'b0};

    // Decode/execute register, bubble on stall
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            toEx.regWrite <= 1'b0;
            toEx.memRead  <= 1'b0;
            toEx.memWrite <= 1'b0;
            toEx.halt     <= 1'b0;
            toEx.zEn      <= 1'b0;
            toEx.vEn      <= 1'b0;
            toEx.nEn      <= 1'b0;
            toEx.aluOp    <= ALU_ADD;
            toEx.srcSel   <= SRC_REG;
            toEx.wbSel    <= WB_ALU;
        end else begin
            toEx.regWrite <= regWrite;
            toEx.memRead  <= memRead;
            toEx.memWrite <= memWrite;
            toEx.halt     <= halt;
            toEx.zEn      <= zEn;
            toEx.vEn      <= vEn;
            toEx.nEn      <= nEn;
            toEx.aluOp    <= aluOp;
            toEx.srcSel   <= srcSel;
            toEx.wbSel    <= wbSel;
        end
    end

    always_ff @(posedge clk) begin
        toEx.rs       <= rs;
        toEx.rt       <= rt;
        toEx.rd       <= instr[11:8];
        toEx.regData1 <= data1;
        toEx.regData2 <= data2;
        toEx.shamt    <= {12'h000, instr[3:0]};
        toEx.offset   <= {{11{instr[3]}}, instr[3:0], 1'b0};
        toEx.byteImm  <= {8'h00, instr[7:0]};
    end

    // A stalled branch must not redirect fetch
    noStallAndBranch: assert property (@(posedge clk) disable iff (rst)
        !(stall && branchTaken));

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            wbEn,
    input  cpuPkg::regIdx_t wbReg,
    input  cpuPkg::word_t   wbData,
    output cpuPkg::flags_t  flags,
    output logic            exSetsFlags,
    output logic            exMemRead,
    output cpuPkg::regIdx_t exRt,
    decodeExIf.dst          fromDec,
    exMemIf.src             toMem
);
    import cpuPkg::*;

    logic    memFwdOk;
    fwdSel_t fwdA;
    fwdSel_t fwdB;
    word_t   opA;
    word_t   regB;
    word_t   opB;
    word_t   aluOut;
    logic    aluV;
    flags_t  aluFlags;

    // Memory stage first, then writeback
    function automatic fwdSel_t pickFwd(regIdx_t src, logic memOk, regIdx_t memRd,
                                        logic wbOk, regIdx_t wbRd);
        if (memOk && memRd != '0 && memRd == src) begin
            return FWD_MEM;
        end else if (wbOk && wbRd != '0 && wbRd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t memVal,
                                     word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // A load in the memory stage has no result yet
    assign memFwdOk = toMem.regWrite && toMem.wbSel == WB_ALU;

    assign fwdA = pickFwd(fromDec.rs, memFwdOk, toMem.rd, wbEn, wbReg);
    assign fwdB = pickFwd(fromDec.rt, memFwdOk, toMem.rd, wbEn, wbReg);
    assign opA  = fwdMux(fwdA, fromDec.regData1, toMem.aluOut, wbData);
    assign regB = fwdMux(fwdB, fromDec.regData2, toMem.aluOut, wbData);

    always_comb begin
        case (fromDec.srcSel)
            SRC_SHAMT:  opB = fromDec.shamt;
            SRC_OFFSET: opB = fromDec.offset;
            SRC_BYTE:   opB = fromDec.byteImm;
            default:    opB = regB;
        endcase
    end

    // ALU
    always_comb begin
        aluV = 1'b0;
        case (fromDec.aluOp)
            ALU_ADD: begin
                aluOut = opA + opB;
                aluV   = (opA[15] == opB[15]) && (aluOut[15] != opA[15]);
            end
            ALU_SUB: begin
                aluOut = opA - opB;
                aluV   = (opA[15] != opB[15]) && (aluOut[15] != opA[15]);
            end
            ALU_XOR: aluOut = opA ^ opB;
            default: aluOut = opA << opB[3:0];
        endcase
    end

    assign aluFlags = {aluOut == '0, aluV, aluOut[15]};

    // ZVN flags, each with its own enable
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else begin
            if (fromDec.zEn) flags[FLAG_Z] <= aluFlags[FLAG_Z];
            if (fromDec.vEn) flags[FLAG_V] <= aluFlags[FLAG_V];
            if (fromDec.nEn) flags[FLAG_N] <= aluFlags[FLAG_N];
        end
    end

    assign exSetsFlags = fromDec.zEn || fromDec.vEn || fromDec.nEn;
    assign exMemRead   = fromDec.memRead;
    assign exRt        = fromDec.rt;

    // Execute/memory register
    always_ff @(posedge clk) begin
        if (rst) begin
            toMem.regWrite <= 1'b0;
            toMem.memWrite <= 1'b0;
            toMem.halt     <= 1'b0;
            toMem.wbSel    <= WB_ALU;
        end else begin
            toMem.regWrite <= fromDec.regWrite;
            toMem.memWrite <= fromDec.memWrite;
            toMem.halt     <= fromDec.halt;
            toMem.wbSel    <= fromDec.wbSel;
        end
    end

    always_ff @(posedge clk) begin
        toMem.rt        <= fromDec.rt;
        toMem.rd        <= fromDec.rd;
        toMem.aluOut    <= aluOut;
        toMem.storeData <= regB;
    end

    // Only LLB uses the byte immediate, and it always writes back
    byteImplWrite: assert property (@(posedge clk) disable iff (rst)
        fromDec.srcSel == SRC_BYTE |-> fromDec.regWrite);

endmodule

// ==== design/memWbStage.sv ====
`timescale 1ns/10ps

module memWbStage #(
    parameter int DMEM_AW = cpuPkg::DMEM_AW
) (
    input  logic            clk,
    input  logic            rst,
    output logic            hlt,
    output logic            wbEn,
    output cpuPkg::regIdx_t wbReg,
    output cpuPkg::word_t   wbData,
    exMemIf.dst             fromEx
);
    import cpuPkg::*;

    word_t  dmem [2**DMEM_AW];
    word_t  storeIn;
    word_t  memOut;
    logic   wRegWrite;
    wbSel_t wSel;
    word_t  wAlu;
    word_t  wMem;

    // MEM-MEM forward for a store right behind its producer
    assign storeIn = (wbEn && wbReg == fromEx.rt) ? wbData : fromEx.storeData;

    always_ff @(posedge clk) begin
        if (fromEx.memWrite) begin
            dmem[fromEx.aluOut[DMEM_AW:1]] <= storeIn;
        end
    end

    assign memOut = dmem[fromEx.aluOut[DMEM_AW:1]];

    // Memory/writeback register, hlt sticks until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            wRegWrite <= 1'b0;
            hlt       <= 1'b0;
        end else begin
            wRegWrite <= fromEx.regWrite;
            hlt       <= hlt || fromEx.halt;
        end
    end

    always_ff @(posedge clk) begin
        wSel  <= fromEx.wbSel;
        wbReg <= fromEx.rd;
        wAlu  <= fromEx.aluOut;
        wMem  <= memOut;
    end

    assign wbEn   = wRegWrite && wbReg != '0;
    assign wbData = (wSel == WB_MEM) ? wMem : wAlu;

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/10ps

module cpu #(
    parameter int IMEM_AW = cpuPkg::IMEM_AW,
    parameter int DMEM_AW = cpuPkg::DMEM_AW
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               loadEn,
    input  logic [IMEM_AW-1:0] loadAddr,
    input  cpuPkg::word_t      loadData,
    output cpuPkg::word_t      pc,
    output logic               hlt,
    output logic               wbEn,
    output cpuPkg::regIdx_t    wbReg,
    output cpuPkg::word_t      wbData
);
    import cpuPkg::*;

    // Fetch/decode
    word_t   fdInstr;
    word_t   fdIncPc;
    logic    stall;
    logic    branchTaken;
    word_t   branchPc;

    // Register file reads
    regIdx_t rs;
    regIdx_t rt;
    word_t   data1;
    word_t   data2;

    // Execute feedback to decode
    flags_t  flags;
    logic    exSetsFlags;
    logic    exMemRead;
    regIdx_t exRt;

    decodeExIf dxBus ();
    exMemIf    xmBus ();

    fetchStage #(.IMEM_AW(IMEM_AW)) fetch (
        .clk, .rst, .loadEn, .loadAddr, .loadData,
        .stall, .branchTaken, .branchPc,
        .pc, .instr(fdInstr), .incPc(fdIncPc)
    );

    decodeStage decode (
        .clk, .rst, .instr(fdInstr), .incPc(fdIncPc),
        .flags, .exSetsFlags, .exMemRead, .exRt, .data1, .data2,
        .rs, .rt, .stall, .branchTaken, .branchPc, .toEx(dxBus.src)
    );

    regFile regs (.clk, .rst, .rs, .rt, .data1, .data2, .wbEn, .wbReg, .wbData);

    executeStage execute (
        .clk, .rst, .wbEn, .wbReg, .wbData,
        .flags, .exSetsFlags, .exMemRead, .exRt,
        .fromDec(dxBus.dst), .toMem(xmBus.src)
    );

    memWbStage #(.DMEM_AW(DMEM_AW)) memWb (
        .clk, .rst, .hlt, .wbEn, .wbReg, .wbData, .fromEx(xmBus.dst)
    );

endmodule

// ==== dv/tbPrograms.svh ====
localparam int NUM_PROGS   = 4;
localparam int TOTAL_WORDS = 52;
localparam int TOTAL_EXP   = 28;

// Where each program sits in PROG_WORDS and EXP_RETIRES
localparam int PROG_START [NUM_PROGS] = '{0, 12, 24, 45};
localparam int PROG_LEN   [NUM_PROGS] = '{12, 12, 21, 7};
localparam int EXP_START  [NUM_PROGS] = '{0, 9, 17, 25};
localparam int EXP_LEN    [NUM_PROGS] = '{9, 8, 8, 3};

// Instruction words of all programs back to back
localparam logic [15:0] PROG_WORDS [TOTAL_WORDS] = '{
    // Forwarding chain, SLL, SUB overflow and a taken B OV
    16'hA105, 16'hA203, 16'h0312, 16'h1431, 16'h3544,
    16'h2653, 16'hA880, 16'h3888, 16'h1981, 16'hCC01,
    16'hA999, 16'hF000,
    // Store, load, load-use stall, store after load
    16'hA110, 16'hA234, 16'h9212, 16'h8312, 16'h0433, 16'h0541,
    16'h9513, 16'h8613, 16'h9614, 16'h8714, 16'h0872, 16'hF000,
    // Branches under each flag outcome
    16'hA101, 16'hA201, 16'h1312, 16'hC201, 16'hA999, 16'hC001,
    16'hA444, 16'h1501, 16'hC601, 16'hA999, 16'hC401, 16'hA666,
    16'hC801, 16'hA777, 16'hCA01, 16'hA999, 16'hCC01, 16'hA888,
    16'hCE01, 16'hA999, 16'hF000,
    // Register 0, and a word after HLT that must not run
    16'hA055, 16'hA112, 16'h0011, 16'h0201, 16'h1300, 16'hF000,
    16'hA3FF
};

// Expected retires as {wbReg, wbData} in program order
localparam logic [19:0] EXP_RETIRES [TOTAL_EXP] = '{
    20'h1_0005, 20'h2_0003, 20'h3_0008, 20'h4_0003, 20'h5_0030,
    20'h6_0038, 20'h8_0080, 20'h8_8000, 20'h9_7FFB,
    20'h1_0010, 20'h2_0034, 20'h3_0034, 20'h4_0068, 20'h5_0078,
    20'h6_0078, 20'h7_0078, 20'h8_00AC,
    20'h1_0001, 20'h2_0001, 20'h3_0000, 20'h4_0044, 20'h5_FFFF,
    20'h6_0066, 20'h7_0077, 20'h8_0088,
    20'h1_0012, 20'h2_0012, 20'h3_0000
};

localparam int CYCLE_LIMIT = 8 * TOTAL_WORDS + 20 * NUM_PROGS;

// ==== dv/cpuTb.sv ====
`timescale 1ns/10ps

module cpuTb;
    import cpuPkg::*;

    `include "tbPrograms.svh"

    logic           clk;
    logic           rst;
    logic           loadEn;
    logic [7:0]     loadAddr;
    logic [15:0]    loadData;
    logic [15:0]    pc;
    logic           hlt;
    logic           wbEn;
    logic [3:0]     wbReg;
    logic [15:0]    wbData;

    int errors;
    int cycleCount;

    cpu #(.IMEM_AW(8), .DMEM_AW(8)) uut (
        .clk, .rst, .loadEn, .loadAddr, .loadData,
        .pc, .hlt, .wbEn, .wbReg, .wbData
    );

    always #5 clk = ~clk;

    // One clock edge, with the run limit
    task automatic tick();
        @(posedge clk);
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the core never halted", cycleCount);
            $display("Errors: %0d", errors + 1);
            $display("Test FAILED");
            $finish;
        end
    endtask

    // Reset held while the program goes into instruction memory
    task automatic resetAndLoad(input int p);
        int n;
        n = (PROG_LEN[p] > 4) ? PROG_LEN[p] : 4;
        for (int i = 0; i < n; i++) begin
            tick();
            rst    <= 1'b1;
            loadEn <= (i < PROG_LEN[p]);
            if (i < PROG_LEN[p]) begin
                loadAddr <= 8'(i);
                loadData <= PROG_WORDS[PROG_START[p] + i];
            end
        end
        tick();
        loadEn <= 1'b0;
        tick();
        assert (pc == 16'h0000) else begin
            $display("error: pc in reset is %h, expected %h", pc, 16'h0000);
            errors++;
        end
        assert (hlt == 1'b0) else begin
            $display("error: hlt in reset is %h, expected %h", hlt, 1'b0);
            errors++;
        end
        rst <= 1'b0;
    endtask

    task automatic runProgram(input int p);
        int idx;
        logic [19:0] exp;
        logic [15:0] haltPc;
        idx = 0;
        resetAndLoad(p);
        tick();
        while (!hlt) begin
            if (wbEn) begin
                assert (idx < EXP_LEN[p]) else begin
                    $display("Program %0d retired more writes than expected", p);
                    errors++;
                end
                if (idx < EXP_LEN[p]) begin
                    exp = EXP_RETIRES[EXP_START[p] + idx];
                    assert (wbReg == exp[19:16]) else begin
                        $display("error: wbReg is %h, expected %h (program %0d, retire %0d)",
                                 wbReg, exp[19:16], p, idx);
                        errors++;
                    end
                    assert (wbData == exp[15:0]) else begin
                        $display("error: wbData is %h, expected %h (program %0d, retire %0d)",
                                 wbData, exp[15:0], p, idx);
                        errors++;
                    end
                end
                idx++;
            end
            tick();
        end
        assert (idx == EXP_LEN[p]) else begin
            $display("Program %0d halted after %0d retires instead of %0d",
                     p, idx, EXP_LEN[p]);
            errors++;
        end

        // Core must stay frozen after halt
        haltPc = pc;
        repeat (10) begin
            tick();
            assert (hlt == 1'b1) else begin
                $display("error: hlt is %h after halt, expected %h", hlt, 1'b1);
                errors++;
            end
            assert (pc == haltPc) else begin
                $display("error: pc is %h after halt, expected %h", pc, haltPc);
                errors++;
            end
            assert (wbEn == 1'b0) else begin
                $display("error: wbEn is %h after halt, expected %h", wbEn, 1'b0);
                errors++;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        errors     = 0;
        cycleCount = 0;

        for (int p = 0; p < NUM_PROGS; p++) begin
            runProgram(p);
        end

        // Last reset, to see hlt and pc clear once more
        tick();
        rst <= 1'b1;
        repeat (4) tick();
        assert (pc == 16'h0000 && hlt == 1'b0) else begin
            $display("error: after reset pc is %h and hlt is %h, expected %h and %h",
                     pc, hlt, 16'h0000, 1'b0);
            errors++;
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+dv
design/cpuPkg.sv
design/pipeIf.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/cpu.sv
dv/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f build.f
./obj_dir/VcpuTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
grep -q "Test OK" sim.log
